//--- include/boot_rom_image.svh
// Boot ROM image: the 64 words of the reset code seen at the ROM base
`ifndef BOOT_ROM_IMAGE_SVH
`define BOOT_ROM_IMAGE_SVH

// Word 0 sits at the ROM base, one 32-bit word per address step of four
`define BOOT_ROM_IMAGE '{ \
  32'h0000_0297, 32'h0202_8593, 32'hf140_2573, 32'h0182_b283, \
  32'h0002_8067, 32'h0000_0000, 32'h8000_0000, 32'h0000_0000, \
  32'h3000_5073, 32'h3040_5073, 32'h0200_02b7, 32'h0002_a023, \
  32'h1050_0073, 32'hffdf_f06f, 32'h0000_0013, 32'h0000_0013, \
  32'hedfe_0dd0, 32'h2c0a_0000, 32'h3800_0000, 32'h480a_0000, \
  32'h2800_0000, 32'h1100_0000, 32'h1000_0000, 32'h0000_0000, \
  32'h0000_0000, 32'hf409_0000, 32'h4c00_0000, 32'h0000_0000, \
  32'h0100_0000, 32'h0000_0000, 32'h0300_0000, 32'h0400_0000, \
  32'h6376_6136, 32'h2d73_6f63, 32'h0000_0000, 32'h0300_0000, \
  32'h0d00_0000, 32'h1b00_0000, 32'h7269_7363, 32'h762c_7269, \
  32'h0100_0000, 32'h6370_7573, 32'h0000_0000, 32'h0300_0000, \
  32'h0400_0000, 32'h0000_0000, 32'h0100_0000, 32'h0300_0000, \
  32'h0400_0000, 32'h1f00_0000, 32'h8096_9800, 32'h0200_0000, \
  32'h0900_0000, 32'h6d65_6d6f, 32'h7279_4080, 32'h0000_0000, \
  32'h0300_0000, 32'h0700_0000, 32'h2f00_0000, 32'h6d65_6d6f, \
  32'h7279_0000, 32'h0200_0000, 32'h0200_0000, 32'h0900_0000  \
}

`endif

//--- design/periph_pkg.sv
// Peripheral subsystem package: bus widths, address map, CLINT offsets and state enums
`default_nettype none

package periph_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned ADDR_WIDTH   = 32;
  localparam int unsigned DATA_WIDTH   = 32;
  localparam int unsigned OFFSET_WIDTH = 16;

  typedef logic [ADDR_WIDTH-1:0]   addr_t;
  typedef logic [DATA_WIDTH-1:0]   data_t;
  typedef logic [OFFSET_WIDTH-1:0] offset_t;

  typedef enum logic [1:0] {
    TGT_ROM,
    TGT_CLINT,
    TGT_NONE
  } target_e;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam addr_t       ROM_BASE      = 32'h0000_0000;
  localparam addr_t       ROM_LENGTH    = 32'h0001_0000;
  localparam int unsigned ROM_WORDS     = 64;
  localparam int unsigned ROM_IDX_WIDTH = $clog2(ROM_WORDS);
  localparam addr_t       CLINT_BASE    = 32'h0200_0000;
  localparam addr_t       CLINT_LENGTH  = 32'h0001_0000;

  // One rule per window, end address is exclusive
  typedef struct packed {
    target_e idx;
    addr_t   start_addr;
    addr_t   end_addr;
  } map_rule_t;

  localparam int unsigned NUM_RULES = 2;
  localparam map_rule_t [NUM_RULES-1:0] ADDR_MAP = '{
    '{idx: TGT_CLINT, start_addr: CLINT_BASE, end_addr: CLINT_BASE + CLINT_LENGTH},
    '{idx: TGT_ROM,   start_addr: ROM_BASE,   end_addr: ROM_BASE + ROM_LENGTH}
  };

  // CLINT register offsets
  localparam offset_t MSIP_OFFSET        = 16'h0000;
  localparam offset_t MTIMECMP_LO_OFFSET = 16'h4000;
  localparam offset_t MTIMECMP_HI_OFFSET = 16'h4004;
  localparam offset_t MTIME_LO_OFFSET    = 16'hBFF8;
  localparam offset_t MTIME_HI_OFFSET    = 16'hBFFC;

  typedef enum logic [2:0] {
    REG_MSIP,
    REG_CMP_LO,
    REG_CMP_HI,
    REG_TIME_LO,
    REG_TIME_HI,
    REG_INVALID
  } clint_reg_e;

  // Debug requests held off this long after reset
  localparam int unsigned DMI_DELAY_CYCLES = 64;
  localparam int unsigned DMI_CNT_WIDTH    = $clog2(DMI_DELAY_CYCLES + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DECODE,
    ST_RESPOND
  } apb_state_e;

endpackage

`default_nettype wire

//--- design/apb_front.sv
// APB front: transfer FSM, request capture and response return from the selected target
`timescale 1ns/1ps
`default_nettype none

module apb_front (
  input  wire logic                clk_i,
  input  wire logic                ndmreset_n,
  input  wire logic                psel_i,
  input  wire logic                penable_i,
  input  wire logic                pwrite_i,
  input  wire periph_pkg::addr_t   paddr_i,
  input  wire periph_pkg::data_t   pwdata_i,
  input  wire periph_pkg::target_e sel_target_i,
  input  wire periph_pkg::data_t   rom_rdata_i,
  input  wire logic                rom_err_i,
  input  wire periph_pkg::data_t   clint_rdata_i,
  input  wire logic                clint_err_i,
  output logic                     req_valid_o,
  output periph_pkg::addr_t        req_addr_o,
  output logic                     req_write_o,
  output periph_pkg::data_t        req_wdata_o,
  output periph_pkg::data_t        prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o
);
  import periph_pkg::*;

  apb_state_e state_q;
  apb_state_e state_d;
  logic       setup_seen;
  data_t      resp_data;
  logic       resp_err;

  // Setup phase of a new transfer
  assign setup_seen = (state_q == ST_IDLE) && psel_i && !penable_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (setup_seen) begin
          state_d = ST_DECODE;
        end
      end
      ST_DECODE:  state_d = ST_RESPOND;
      ST_RESPOND: state_d = ST_IDLE;
      default:    state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q     <= ST_IDLE;
      req_valid_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      req_valid_o <= setup_seen;
    end
  end

  always_ff @(posedge clk_i) begin
    if (setup_seen) begin
      req_addr_o  <= paddr_i;
      req_write_o <= pwrite_i;
      req_wdata_o <= pwdata_i;
    end
  end

  // ----------------------------------------
  // Response return
  // ----------------------------------------
  always_comb begin
    case (sel_target_i)
      TGT_ROM: begin
        resp_data = rom_rdata_i;
        resp_err  = rom_err_i;
      end
      TGT_CLINT: begin
        resp_data = clint_rdata_i;
        resp_err  = clint_err_i;
      end
      default: begin
        resp_data = '0;
        resp_err  = 1'b1;
      end
    endcase
  end

  assign pready_o  = (state_q == ST_RESPOND);
  assign pslverr_o = pready_o && resp_err;
  assign prdata_o  = (pready_o && !resp_err) ? resp_data : '0;

endmodule

`default_nettype wire

//--- design/addr_decode.sv
// Address decode: matches the captured address against the map rules, registers target and offset
`timescale 1ns/1ps
`default_nettype none

module addr_decode (
  input  wire logic              clk_i,
  input  wire logic              ndmreset_n,
  input  wire logic              req_valid_i,
  input  wire periph_pkg::addr_t req_addr_i,
  input  wire logic              req_write_i,
  input  wire periph_pkg::data_t req_wdata_i,
  output logic                   sel_valid_o,
  output periph_pkg::target_e    sel_target_o,
  output periph_pkg::offset_t    sel_offset_o,
  output logic                   sel_write_o,
  output periph_pkg::data_t      sel_wdata_o
);
  import periph_pkg::*;

  target_e hit_target;
  addr_t   hit_base;
  addr_t   rel_addr;

  // Start inclusive, end exclusive
  always_comb begin
    hit_target = TGT_NONE;
    hit_base   = '0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (req_addr_i >= ADDR_MAP[i].start_addr && req_addr_i < ADDR_MAP[i].end_addr) begin
        hit_target = ADDR_MAP[i].idx;
        hit_base   = ADDR_MAP[i].start_addr;
      end
    end
  end

  assign rel_addr = req_addr_i - hit_base;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      sel_valid_o  <= 1'b0;
      sel_target_o <= TGT_NONE;
    end else begin
      sel_valid_o <= req_valid_i;
      if (req_valid_i) begin
        sel_target_o <= hit_target;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      sel_offset_o <= rel_addr[OFFSET_WIDTH-1:0];
      sel_write_o  <= req_write_i;
      sel_wdata_o  <= req_wdata_i;
    end
  end

endmodule

`default_nettype wire

//--- design/clint_timer.sv
// CLINT timer: mtime, mtimecmp and msip registers with timer and software interrupts
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
  input  wire logic                clk_i,
  input  wire logic                ndmreset_n,
  input  wire logic                rtc_i,
  input  wire logic                sel_valid_i,
  input  wire periph_pkg::target_e sel_target_i,
  input  wire periph_pkg::offset_t sel_offset_i,
  input  wire logic                sel_write_i,
  input  wire periph_pkg::data_t   sel_wdata_i,
  output periph_pkg::data_t        rdata_o,
  output logic                     err_o,
  output logic                     timer_irq_o,
  output logic                     ipi_o
);
  import periph_pkg::*;

  clint_reg_e              reg_sel;
  logic                    wr_en;
  logic                    rtc_toggle_q;
  logic                    rtc_tick;
  logic                    msip_q;
  logic [2*DATA_WIDTH-1:0] mtime_q;
  logic [2*DATA_WIDTH-1:0] mtimecmp_q;

  always_comb begin
    case (sel_offset_i)
      MSIP_OFFSET:        reg_sel = REG_MSIP;
      MTIMECMP_LO_OFFSET: reg_sel = REG_CMP_LO;
      MTIMECMP_HI_OFFSET: reg_sel = REG_CMP_HI;
      MTIME_LO_OFFSET:    reg_sel = REG_TIME_LO;
      MTIME_HI_OFFSET:    reg_sel = REG_TIME_HI;
      default:            reg_sel = REG_INVALID;
    endcase
  end

  // Only high in the response cycle of a CLINT write
  assign wr_en = sel_valid_i && sel_write_i && (sel_target_i == TGT_CLINT);

  // ----------------------------------------
  // RTC divide by two
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_toggle_q <= 1'b0;
    end else if (rtc_i) begin
      rtc_toggle_q <= ~rtc_toggle_q;
    end
  end

  assign rtc_tick = rtc_i && rtc_toggle_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      // Software write to mtime wins over the tick
      if (wr_en && reg_sel == REG_TIME_LO) begin
        mtime_q[DATA_WIDTH-1:0] <= sel_wdata_i;
      end else if (wr_en && reg_sel == REG_TIME_HI) begin
        mtime_q[2*DATA_WIDTH-1:DATA_WIDTH] <= sel_wdata_i;
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && reg_sel == REG_CMP_LO) begin
        mtimecmp_q[DATA_WIDTH-1:0] <= sel_wdata_i;
      end
      if (wr_en && reg_sel == REG_CMP_HI) begin
        mtimecmp_q[2*DATA_WIDTH-1:DATA_WIDTH] <= sel_wdata_i;
      end
      if (wr_en && reg_sel == REG_MSIP) begin
        msip_q <= sel_wdata_i[0];
      end
    end
  end

  always_comb begin
    case (reg_sel)
      REG_MSIP:    rdata_o = {{(DATA_WIDTH-1){1'b0}}, msip_q};
      REG_CMP_LO:  rdata_o = mtimecmp_q[DATA_WIDTH-1:0];
      REG_CMP_HI:  rdata_o = mtimecmp_q[2*DATA_WIDTH-1:DATA_WIDTH];
      REG_TIME_LO: rdata_o = mtime_q[DATA_WIDTH-1:0];
      REG_TIME_HI: rdata_o = mtime_q[2*DATA_WIDTH-1:DATA_WIDTH];
      default:     rdata_o = '0;
    endcase
  end

  assign err_o       = (sel_target_i == TGT_CLINT) && (reg_sel == REG_INVALID);
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

`default_nettype wire

//--- design/boot_rom.sv
// Boot ROM: read-only word array holding the reset code image
`timescale 1ns/1ps
`default_nettype none

`include "boot_rom_image.svh"

module boot_rom (
  input  wire periph_pkg::target_e sel_target_i,
  input  wire periph_pkg::offset_t sel_offset_i,
  input  wire logic                sel_write_i,
  output periph_pkg::data_t        rdata_o,
  output logic                     err_o
);
  import periph_pkg::*;

  localparam data_t ROM_IMAGE [ROM_WORDS] = `BOOT_ROM_IMAGE;

  logic [OFFSET_WIDTH-3:0] word_idx;
  logic                    in_image;

  // Word addressed, low two offset bits ignored
  assign word_idx = sel_offset_i[OFFSET_WIDTH-1:2];
  assign in_image = (word_idx < ROM_WORDS);

  assign rdata_o = in_image ? ROM_IMAGE[word_idx[ROM_IDX_WIDTH-1:0]] : '0;

  // Writes and reads past the image are refused
  assign err_o = (sel_target_i == TGT_ROM) && (sel_write_i || !in_image);

endmodule

`default_nettype wire

//--- design/debug_gate.sv
// Debug gate: holds debug requests off for a fixed number of cycles after reset
`timescale 1ns/1ps
`default_nettype none

module debug_gate (
  input  wire logic clk_i,
  input  wire logic ndmreset_n,
  input  wire logic debug_req_i,
  output logic      debug_req_o
);
  import periph_pkg::*;

  logic [DMI_CNT_WIDTH-1:0] delay_cnt_q;

  // Counts down once after reset, then sits at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      delay_cnt_q <= DMI_CNT_WIDTH'(DMI_DELAY_CYCLES);
    end else if (delay_cnt_q != '0) begin
      delay_cnt_q <= delay_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (delay_cnt_q == '0) && debug_req_i;

endmodule

`default_nettype wire

//--- design/periph_subsystem.sv
// Peripheral subsystem top: APB front, address decode, boot ROM, CLINT timer, debug gate
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem (
  input  wire logic                clk_i,
  input  wire logic                ndmreset_n,
  // APB completer
  input  wire logic                psel_i,
  input  wire logic                penable_i,
  input  wire logic                pwrite_i,
  input  wire periph_pkg::addr_t   paddr_i,
  input  wire periph_pkg::data_t   pwdata_i,
  output periph_pkg::data_t        prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  // Timer and debug
  input  wire logic                rtc_i,
  input  wire logic                debug_req_i,
  output logic                     timer_irq_o,
  output logic                     ipi_o,
  output logic                     debug_req_o
);
  import periph_pkg::*;

  logic    req_valid;
  addr_t   req_addr;
  logic    req_write;
  data_t   req_wdata;

  logic    sel_valid;
  target_e sel_target;
  offset_t sel_offset;
  logic    sel_write;
  data_t   sel_wdata;

  data_t   rom_rdata;
  logic    rom_err;
  data_t   clint_rdata;
  logic    clint_err;

  apb_front u_apb_front (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .psel_i        ( psel_i      ),
    .penable_i     ( penable_i   ),
    .pwrite_i      ( pwrite_i    ),
    .paddr_i       ( paddr_i     ),
    .pwdata_i      ( pwdata_i    ),
    .sel_target_i  ( sel_target  ),
    .rom_rdata_i   ( rom_rdata   ),
    .rom_err_i     ( rom_err     ),
    .clint_rdata_i ( clint_rdata ),
    .clint_err_i   ( clint_err   ),
    .req_valid_o   ( req_valid   ),
    .req_addr_o    ( req_addr    ),
    .req_write_o   ( req_write   ),
    .req_wdata_o   ( req_wdata   ),
    .prdata_o      ( prdata_o    ),
    .pready_o      ( pready_o    ),
    .pslverr_o     ( pslverr_o   )
  );

  addr_decode u_addr_decode (
    .clk_i        ( clk_i      ),
    .ndmreset_n   ( ndmreset_n ),
    .req_valid_i  ( req_valid  ),
    .req_addr_i   ( req_addr   ),
    .req_write_i  ( req_write  ),
    .req_wdata_i  ( req_wdata  ),
    .sel_valid_o  ( sel_valid  ),
    .sel_target_o ( sel_target ),
    .sel_offset_o ( sel_offset ),
    .sel_write_o  ( sel_write  ),
    .sel_wdata_o  ( sel_wdata  )
  );

  clint_timer u_clint_timer (
    .clk_i        ( clk_i       ),
    .ndmreset_n   ( ndmreset_n  ),
    .rtc_i        ( rtc_i       ),
    .sel_valid_i  ( sel_valid   ),
    .sel_target_i ( sel_target  ),
    .sel_offset_i ( sel_offset  ),
    .sel_write_i  ( sel_write   ),
    .sel_wdata_i  ( sel_wdata   ),
    .rdata_o      ( clint_rdata ),
    .err_o        ( clint_err   ),
    .timer_irq_o  ( timer_irq_o ),
    .ipi_o        ( ipi_o       )
  );

  boot_rom u_boot_rom (
    .sel_target_i ( sel_target ),
    .sel_offset_i ( sel_offset ),
    .sel_write_i  ( sel_write  ),
    .rdata_o      ( rom_rdata  ),
    .err_o        ( rom_err    )
  );

  debug_gate u_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

//--- tb/periph_assertions.sv
// Peripheral subsystem assertions: APB response timing and debug gate hold-off
`timescale 1ns/1ps
`default_nettype none

module periph_assertions (
  input wire logic clk_i,
  input wire logic ndmreset_n,
  input wire logic psel_i,
  input wire logic penable_i,
  input wire logic pready_o,
  input wire logic pslverr_o,
  input wire logic debug_req_o
);
  import periph_pkg::*;

  logic [DMI_CNT_WIDTH-1:0] cycles_q;

  // Cycles since reset release, stops at the gate delay
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cycles_q <= '0;
    end else if (cycles_q != DMI_CNT_WIDTH'(DMI_DELAY_CYCLES)) begin
      cycles_q <= cycles_q + 1'b1;
    end
  end

  // ----------------------------------------
  // APB response
  // ----------------------------------------
  ready_in_access: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    pready_o |-> (psel_i && penable_i))
    else $error("pready_o high outside an access phase");

  err_with_ready: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    pslverr_o |-> pready_o)
    else $error("pslverr_o high without pready_o");

  // One wait state: setup, first access cycle, then ready
  ready_after_wait: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    pready_o |-> ($past(psel_i && !penable_i, 2) && $past(penable_i && !pready_o, 1)))
    else $error("pready_o not two cycles after the setup phase");

  ready_on_time: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (psel_i && penable_i && $past(psel_i && !penable_i, 2)) |-> pready_o)
    else $error("pready_o missing in the second access cycle");

  gate_holds_debug: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (cycles_q < DMI_CNT_WIDTH'(DMI_DELAY_CYCLES)) |-> !debug_req_o)
    else $error("debug_req_o passed during the post-reset delay");

endmodule

bind periph_subsystem periph_assertions u_periph_assertions (
  .clk_i       ( clk_i       ),
  .ndmreset_n  ( ndmreset_n  ),
  .psel_i      ( psel_i      ),
  .penable_i   ( penable_i   ),
  .pready_o    ( pready_o    ),
  .pslverr_o   ( pslverr_o   ),
  .debug_req_o ( debug_req_o )
);

`default_nettype wire

//--- tb/periph_tb.sv
// Peripheral subsystem testbench: directed APB tests of boot ROM, CLINT and debug gate
`timescale 1ns/1ps
`default_nettype none

`include "boot_rom_image.svh"

module periph_tb;
  import periph_pkg::*;

  localparam int    APB_TIMEOUT     = 16;
  localparam int    RTC_PULSE_LIMIT = 64;
  localparam data_t ROM_IMAGE [ROM_WORDS] = `BOOT_ROM_IMAGE;

  logic  clk_i;
  logic  ndmreset_n;
  logic  psel_i;
  logic  penable_i;
  logic  pwrite_i;
  addr_t paddr_i;
  data_t pwdata_i;
  data_t prdata_o;
  logic  pready_o;
  logic  pslverr_o;
  logic  rtc_i;
  logic  debug_req_i;
  logic  timer_irq_o;
  logic  ipi_o;
  logic  debug_req_o;
  integer seed;

  periph_subsystem uut (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .psel_i      ( psel_i      ),
    .penable_i   ( penable_i   ),
    .pwrite_i    ( pwrite_i    ),
    .paddr_i     ( paddr_i     ),
    .pwdata_i    ( pwdata_i    ),
    .prdata_o    ( prdata_o    ),
    .pready_o    ( pready_o    ),
    .pslverr_o   ( pslverr_o   ),
    .rtc_i       ( rtc_i       ),
    .debug_req_i ( debug_req_i ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic report_and_stop(input string line);
    $display("%s", line);
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      report_and_stop($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_and_stop($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_and_stop($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // ----------------------------------------
  // APB driver
  // ----------------------------------------
  task automatic apb_transfer(input logic write, input addr_t addr, input data_t wdata,
                              output data_t rdata, output logic err);
    int waited;
    waited = 0;
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    while (!pready_o && waited < APB_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!pready_o) begin
      report_and_stop($sformatf("APB transfer to 0x%h never saw pready_o", addr));
    end
    check_data("wait states before pready_o", waited, 1);
    rdata = prdata_o;
    err   = pslverr_o;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input addr_t addr, input data_t wdata,
                           output data_t rdata, output logic err);
    apb_transfer(1'b1, addr, wdata, rdata, err);
  endtask

  task automatic apb_read(input addr_t addr, output data_t rdata, output logic err);
    apb_transfer(1'b0, addr, '0, rdata, err);
  endtask

  task automatic rtc_pulse();
    rtc_i = 1'b1;
    @(negedge clk_i);
    rtc_i = 1'b0;
    @(negedge clk_i);
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_debug_gate();
    for (int i = 0; i < DMI_DELAY_CYCLES; i++) begin
      check_bit("debug_req_o during delay", debug_req_o, 1'b0);
      @(negedge clk_i);
    end
    check_bit("debug_req_o after delay", debug_req_o, 1'b1);
    debug_req_i = 1'b0;
    @(negedge clk_i);
    check_bit("debug_req_o with request low", debug_req_o, 1'b0);
  endtask

  task automatic test_rom_reads();
    int    idx;
    data_t rdata;
    logic  err;
    for (int n = 0; n < 8; n++) begin
      idx = $unsigned($random(seed)) % ROM_WORDS;
      apb_read(ROM_BASE + addr_t'(idx * 4), rdata, err);
      check_err("pslverr_o on rom read", err, 1'b0);
      check_data("prdata_o from rom", rdata, ROM_IMAGE[idx]);
    end
    apb_write(ROM_BASE + 32'h8, data_t'($random(seed)), rdata, err);
    check_err("pslverr_o on rom write", err, 1'b1);
  endtask

  task automatic test_unmapped();
    addr_t bad_addr [5];
    data_t rdata;
    logic  err;
    // Outside both windows, past the ROM image, unused CLINT offsets
    bad_addr = '{32'h1000_0000, 32'h0300_0000, 32'h0000_0100, 32'h0200_0008, 32'h0200_8000};
    for (int i = 0; i < 5; i++) begin
      apb_read(bad_addr[i], rdata, err);
      check_err("pslverr_o on unmapped read", err, 1'b1);
      check_data("prdata_o on unmapped read", rdata, '0);
      apb_write(bad_addr[i], data_t'($random(seed)), rdata, err);
      check_err("pslverr_o on unmapped write", err, 1'b1);
      check_data("prdata_o on unmapped write", rdata, '0);
    end
  endtask

  task automatic test_msip();
    data_t rdata;
    logic  err;
    apb_write(CLINT_BASE + MSIP_OFFSET, 32'h1, rdata, err);
    check_err("pslverr_o on msip write", err, 1'b0);
    check_bit("ipi_o after msip set", ipi_o, 1'b1);
    apb_read(CLINT_BASE + MSIP_OFFSET, rdata, err);
    check_data("msip readback", rdata, 32'h1);
    apb_write(CLINT_BASE + MSIP_OFFSET, 32'h0, rdata, err);
    check_bit("ipi_o after msip clear", ipi_o, 1'b0);
    apb_read(CLINT_BASE + MSIP_OFFSET, rdata, err);
    check_data("msip readback", rdata, 32'h0);
  endtask

  task automatic test_timer();
    data_t n;
    int    pulses;
    data_t rdata;
    logic  err;
    n = 1 + ($unsigned($random(seed)) % 8);
    apb_write(CLINT_BASE + MTIMECMP_HI_OFFSET, '0, rdata, err);
    apb_write(CLINT_BASE + MTIMECMP_LO_OFFSET, n, rdata, err);
    check_err("pslverr_o on mtimecmp write", err, 1'b0);
    apb_write(CLINT_BASE + MTIME_LO_OFFSET, '0, rdata, err);
    apb_write(CLINT_BASE + MTIME_HI_OFFSET, '0, rdata, err);
    check_bit("timer_irq_o before ticks", timer_irq_o, 1'b0);
    // Two rtc pulses per mtime step
    pulses = 0;
    while (!timer_irq_o && pulses < RTC_PULSE_LIMIT) begin
      rtc_pulse();
      pulses++;
    end
    if (!timer_irq_o) begin
      report_and_stop("timer_irq_o did not rise within the rtc pulse limit");
    end
    check_data("rtc pulses until timer_irq_o", pulses, 2 * n);
    apb_read(CLINT_BASE + MTIME_LO_OFFSET, rdata, err);
    check_data("mtime low", rdata, n);
    apb_read(CLINT_BASE + MTIME_HI_OFFSET, rdata, err);
    check_data("mtime high", rdata, '0);
  endtask

  task automatic test_timer_rearm();
    data_t now;
    data_t rdata;
    logic  err;
    check_bit("timer_irq_o before rearm", timer_irq_o, 1'b1);
    apb_read(CLINT_BASE + MTIME_LO_OFFSET, now, err);
    apb_write(CLINT_BASE + MTIMECMP_LO_OFFSET, now + 3, rdata, err);
    check_err("pslverr_o on mtimecmp rearm", err, 1'b0);
    check_bit("timer_irq_o after rearm", timer_irq_o, 1'b0);
    repeat (4) rtc_pulse();
    check_bit("timer_irq_o two ticks later", timer_irq_o, 1'b0);
    repeat (2) rtc_pulse();
    check_bit("timer_irq_o three ticks later", timer_irq_o, 1'b1);
  endtask

  initial begin
    seed        = 32'h677b;
    ndmreset_n  = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    rtc_i       = 1'b0;
    debug_req_i = 1'b1;
    repeat (10) @(negedge clk_i);
    ndmreset_n = 1'b1;
    test_debug_gate();
    test_rom_reads();
    test_unmapped();
    test_msip();
    test_timer();
    test_timer_rearm();
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
design/periph_pkg.sv
design/apb_front.sv
design/addr_decode.sv
design/clint_timer.sv
design/boot_rom.sv
design/debug_gate.sv
design/periph_subsystem.sv
tb/periph_assertions.sv
tb/periph_tb.sv

//--- Makefile
# Verilator build, run and lint of the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "Simulation ended without passing"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
